/* all.f */
+incdir+rtl
rtl/cm3_pkg.sv
rtl/cm3_addr_hold.sv
rtl/cm3_code_mux.sv
rtl/cm3_excl_mon.sv
rtl/cm3_bus_wrap.sv
verification/cm3_bus_wrap_checker.sv
verification/cm3_bus_wrap_monitor.sv
verification/cm3_bus_wrap_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module cm3_bus_wrap_tb -f all.f -o simv

status=0
./obj_dir/simv > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "Simulation finished: FAIL" sim.log; then
   echo "Run failed, see sim.log"
   exit 1
fi
exit 0

/* verification/cm3_bus_wrap_tb.sv */
//==========================================================================
// Cortex-M3 bus logic testbench
// Drives icode, dcode and system bus traffic from an operation table
//==========================================================================
`timescale 1ns/1ps
`default_nettype none
`include "cm3_defines.svh"

module cm3_bus_wrap_tb;
   import cm3_pkg::*;

   localparam int CLK_PERIOD = 20;
   localparam int NUM_OPS    = 16;

   typedef enum logic [2:0] {OP_IFETCH, OP_DCODE, OP_BOTH, OP_SYS, OP_HALT} tOpKind;

   typedef struct {
      tOpKind      kind;
      logic [31:0] addr;
      logic        write;
      logic        exReq;
      logic        halted;
      logic        expWrite;   // sysWrite in the address phase
      logic        expExResp;  // sysExResp in the data phase
   } tOp;

   logic                   HCLK;
   logic                   rst;
   tIcodeReq               icodeReq;
   tCodeResp               icodeResp;
   tDcodeReq               dcodeReq;
   logic [`CM3_DATA_W-1:0] dcodeWdata;
   tCodeResp               dcodeResp;
   tCodeReq                codeReq;
   logic [`CM3_DATA_W-1:0] codeWdata;
   tCodeResp               codeResp;
   logic                   sysWriteIn;
   logic [`CM3_ADDR_W-1:0] sysAddr;
   logic                   sysExReq;
   logic                   sysReady;
   logic                   halted;
   logic                   sysWrite;
   logic                   sysExResp;
   logic                   expSys;
   logic                   expWrite;
   logic                   expExResp;
   int                     errorCount;
   tOp                     ops [NUM_OPS];
   logic                   slvBusy;   // Code slave data phase in flight
   logic [31:0]            slvAddr;
   int                     slvWait;

   cm3_bus_wrap u_cm3_bus_wrap (.*);

   cm3_bus_wrap_monitor u_monitor (.*);

   always #(CLK_PERIOD / 2) HCLK = ~HCLK;

   // Code slave, 0 to 2 wait states per data phase
   always @(posedge HCLK) begin
      if (rst) begin
         slvBusy <= 1'b0;
         slvWait <= 0;
      end else if (codeResp.ready) begin
         slvBusy <= codeReq.trans[1];
         slvAddr <= codeReq.addr;
         slvWait <= int'($urandom % 3);
      end else begin
         slvWait <= slvWait - 1;
      end
   end

   initial begin
      codeResp = '{rdata: '0, ready: 1'b1, resp: 1'b0};
      forever begin
         @(negedge HCLK);
         codeResp.ready = rst || !slvBusy || slvWait == 0;
         codeResp.rdata = slvBusy ? (slvAddr ^ 32'hC0DE_0000) : '0;
         codeResp.resp  = 1'b0;
      end
   end

   // Each master holds its request until its own ready accepts it
   task automatic runCode(input logic iGo, input logic [31:0] iAddr, input logic dGo,
                          input logic [31:0] dAddr, input logic dWrite);
      logic iWait;
      logic dWait;
      iWait          = iGo;
      dWait          = dGo;
      icodeReq.trans = iGo ? `CM3_HTRANS_NONSEQ : `CM3_HTRANS_IDLE;
      icodeReq.addr  = iAddr;
      icodeReq.prot  = 4'b1010;   // Cacheable privileged opcode fetch
      dcodeReq.trans = dGo ? `CM3_HTRANS_NONSEQ : `CM3_HTRANS_IDLE;
      dcodeReq.addr  = dAddr;
      dcodeReq.write = dWrite;
      dcodeReq.prot  = 4'b1011;
      dcodeWdata     = dAddr ^ 32'h5A5A_5A5A;
      while (iWait || dWait) begin
         @(posedge HCLK);
         if (icodeResp.ready) iWait = 1'b0;
         if (dcodeResp.ready) dWait = 1'b0;
         @(negedge HCLK);
         if (!iWait) icodeReq.trans = `CM3_HTRANS_IDLE;
         if (!dWait) dcodeReq.trans = `CM3_HTRANS_IDLE;
      end
      do @(posedge HCLK); while (!(icodeResp.ready && dcodeResp.ready));
      @(negedge HCLK);
   endtask

   task automatic runSys(input tOp op);
      sysAddr    = op.addr;
      sysWriteIn = op.write;
      sysExReq   = op.exReq;
      halted     = op.halted;
      expSys     = op.kind == OP_SYS;
      expWrite   = op.expWrite;
      expExResp  = op.expExResp;
      @(negedge HCLK);
      sysWriteIn = 1'b0;
      sysExReq   = 1'b0;
      halted     = 1'b0;
      expSys     = 1'b0;
      @(negedge HCLK);
   endtask

   initial begin
      ops[0]  = '{OP_IFETCH, 32'h0000_1000, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0};
      ops[1]  = '{OP_DCODE,  32'h0000_2000, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0};
      ops[2]  = '{OP_BOTH,   32'h0000_3000, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0};
      ops[3]  = '{OP_BOTH,   32'h0000_3010, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0};
      ops[4]  = '{OP_BOTH,   32'h0000_3020, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0};
      ops[5]  = '{OP_DCODE,  32'h0000_4000, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0};
      ops[6]  = '{OP_DCODE,  32'h0000_4000, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0};
      ops[7]  = '{OP_SYS,    32'h2000_0010, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0};
      ops[8]  = '{OP_SYS,    32'h2000_0010, 1'b1, 1'b1, 1'b0, 1'b1, 1'b0};
      ops[9]  = '{OP_SYS,    32'h2000_0010, 1'b1, 1'b1, 1'b0, 1'b0, 1'b1}; // Tag used up
      ops[10] = '{OP_SYS,    32'h2000_0020, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0};
      ops[11] = '{OP_SYS,    32'h2000_0040, 1'b1, 1'b1, 1'b0, 1'b0, 1'b1}; // Other word
      ops[12] = '{OP_SYS,    32'h2000_0050, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0};
      ops[13] = '{OP_HALT,   32'h0000_0000, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0};
      ops[14] = '{OP_SYS,    32'h2000_0050, 1'b1, 1'b1, 1'b0, 1'b0, 1'b1};
      ops[15] = '{OP_SYS,    32'h2000_0060, 1'b1, 1'b0, 1'b0, 1'b1, 1'b0}; // Plain store
   end

   initial begin
      void'($urandom(21));
      HCLK       = 1'b0;
      rst        = 1'b1;
      icodeReq   = '0;
      dcodeReq   = '0;
      dcodeWdata = '0;
      sysWriteIn = 1'b0;
      sysAddr    = '0;
      sysExReq   = 1'b0;
      sysReady   = 1'b1;
      halted     = 1'b0;
      expSys     = 1'b0;
      expWrite   = 1'b0;
      expExResp  = 1'b0;
      repeat (3) @(posedge HCLK);
      @(negedge HCLK);
      rst = 1'b0;
      @(negedge HCLK);
      for (int i = 0; i < NUM_OPS; i++) begin
         case (ops[i].kind)
            OP_IFETCH: runCode(1'b1, ops[i].addr, 1'b0, '0, 1'b0);
            OP_DCODE:  runCode(1'b0, '0, 1'b1, ops[i].addr, ops[i].write);
            OP_BOTH:   runCode(1'b1, ops[i].addr + 32'h100, 1'b1, ops[i].addr, 1'b0);
            default:   runSys(ops[i]);
         endcase
      end
      repeat (2) @(negedge HCLK);
      $display("Checks done with %0d errors", errorCount);
      if (errorCount == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

   // Watchdog
   initial begin
      #((NUM_OPS * 10 + 50) * CLK_PERIOD);
      $display("Timeout: the operation table did not finish in time");
      $display("Checks done with %0d errors", errorCount);
      $display("Simulation finished: FAIL");
      $finish;
   end

endmodule

`default_nettype wire

/* verification/cm3_bus_wrap_monitor.sv */
//==========================================================================
// Bus wrapper monitor
// Predicts code bus data, arbitration order and exclusive results
//==========================================================================
`timescale 1ns/1ps
`default_nettype none
`include "cm3_defines.svh"

module cm3_bus_wrap_monitor (
   input  logic              HCLK,
   input  logic              rst,
   input  cm3_pkg::tIcodeReq icodeReq,
   input  cm3_pkg::tCodeResp icodeResp,
   input  cm3_pkg::tDcodeReq dcodeReq,
   input  logic [31:0]       dcodeWdata,
   input  cm3_pkg::tCodeResp dcodeResp,
   input  cm3_pkg::tCodeReq  codeReq,
   input  logic [31:0]       codeWdata,
   input  cm3_pkg::tCodeResp codeResp,
   input  logic              sysWrite,
   input  logic              sysExResp,
   input  logic              expSys,
   input  logic              expWrite,
   input  logic              expExResp,
   output int                errorCount
);
   import cm3_pkg::*;

   localparam logic [31:0] RDATA_KEY = 32'hC0DE_0000; // Slave read data pattern

   logic        rstQ;
   logic        iAcc;
   logic        dAcc;
   logic        iOut;        // Icode data phase outstanding
   logic        dOut;
   logic        dWriteQ;
   logic        orderWait;   // Icode must be the next bus address
   logic        respPend;
   logic        respExp;
   logic [31:0] iAddrQ;
   logic [31:0] dAddrQ;
   logic [31:0] orderAddr;

   task automatic compareValue(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
      if (expected !== actual) begin
         $display("Error: %0t %s expected %h actual %h", $time, name, expected, actual);
         errorCount++;
      end
   endtask

   always @(posedge HCLK) begin
      iAcc = icodeResp.ready && icodeReq.trans[1];
      dAcc = dcodeResp.ready && dcodeReq.trans[1];
      if (rst) begin
         errorCount = 0;
         iOut       = 1'b0;
         dOut       = 1'b0;
         orderWait  = 1'b0;
         respPend   = 1'b0;
      end else begin
         if (rstQ) begin
            compareValue("codeReq.trans", 32'(`CM3_HTRANS_IDLE), 32'(codeReq.trans));
            compareValue("icodeResp.ready", 32'd1, 32'(icodeResp.ready));
            compareValue("dcodeResp.ready", 32'd1, 32'(dcodeResp.ready));
            compareValue("sysExResp", 32'd0, 32'(sysExResp));
         end
         if (iOut && icodeResp.ready) begin
            compareValue("icodeResp.rdata", iAddrQ ^ RDATA_KEY, icodeResp.rdata);
            iOut = 1'b0;
         end
         if (dOut && dcodeResp.ready) begin
            if (dWriteQ) compareValue("codeWdata", dcodeWdata, codeWdata);
            else compareValue("dcodeResp.rdata", dAddrQ ^ RDATA_KEY, dcodeResp.rdata);
            dOut = 1'b0;
         end
         if (orderWait && codeResp.ready && codeReq.trans[1]) begin
            compareValue("codeReq.addr", orderAddr, codeReq.addr);
            orderWait = 1'b0;
         end
         // Dcode wins unless icode is already waiting
         if (dAcc && icodeResp.ready) begin
            compareValue("codeReq.addr", dcodeReq.addr, codeReq.addr);
            compareValue("codeReq.write", 32'(dcodeReq.write), 32'(codeReq.write));
            compareValue("codeReq.prot", 32'(dcodeReq.prot), 32'(codeReq.prot));
         end
         if (iAcc && dcodeResp.ready && !dcodeReq.trans[1]) begin
            compareValue("codeReq.addr", icodeReq.addr, codeReq.addr);
            compareValue("codeReq.write", 32'd0, 32'(codeReq.write)); // Fetch is a read
            compareValue("codeReq.prot", 32'(icodeReq.prot), 32'(codeReq.prot));
         end
         if (iAcc && dAcc) begin
            orderWait = 1'b1;
            orderAddr = icodeReq.addr;
         end
         if (iAcc) begin
            iOut   = 1'b1;
            iAddrQ = icodeReq.addr;
         end
         if (dAcc) begin
            dOut    = 1'b1;
            dAddrQ  = dcodeReq.addr;
            dWriteQ = dcodeReq.write;
         end
         if (respPend) begin
            compareValue("sysExResp", 32'(respExp), 32'(sysExResp));
            respPend = 1'b0;
         end
         if (expSys) begin
            compareValue("sysWrite", 32'(expWrite), 32'(sysWrite));
            respPend = 1'b1;
            respExp  = expExResp;
         end
      end
      rstQ = rst;
   end

endmodule

`default_nettype wire

/* verification/cm3_bus_wrap_checker.sv */
//==========================================================================
// Code bus mux protocol checker
// Address hold, pending stall and single data phase rules
//==========================================================================
`timescale 1ns/1ps
`default_nettype none

module cm3_bus_wrap_checker (
   input logic              HCLK,
   input logic              rst,
   input cm3_pkg::tIcodeReq icodeReq,
   input cm3_pkg::tDcodeReq dcodeReq,
   input cm3_pkg::tCodeReq  codeReq,
   input cm3_pkg::tCodeResp codeResp,
   input cm3_pkg::tCodeResp icodeResp,
   input cm3_pkg::tCodeResp dcodeResp,
   input logic              iPending,
   input logic              dPending,
   input logic              iIssued,
   input logic              dIssued,
   input logic              ownValidQ
);

   logic iLost;   // Icode sits in its holding register next cycle
   logic dLost;

   assign iLost = ((icodeReq.trans[1] && icodeResp.ready) || iPending) && !iIssued;
   assign dLost = ((dcodeReq.trans[1] && dcodeResp.ready) || dPending) && !dIssued;

   // Stalled address phase stays on the bus
   assert property (@(posedge HCLK) disable iff (rst)
      (codeReq.trans[1] && !codeResp.ready) |=> $stable(codeReq))
      else $error("codeReq changed while its address phase was stalled");

   // A master that lost the bus is stalled until its held copy goes out
   assert property (@(posedge HCLK) disable iff (rst)
      !($past(iLost) && icodeResp.ready) && !($past(dLost) && dcodeResp.ready))
      else $error("master ready high while its request was pending");

   // Data phase flag moves only when an address phase is accepted
   assert property (@(posedge HCLK) disable iff (rst)
      ownValidQ == $past(codeResp.ready ? codeReq.trans[1] : ownValidQ))
      else $error("second data phase started before the first completed");

endmodule

bind cm3_code_mux cm3_bus_wrap_checker u_checker (
   .HCLK      (HCLK),
   .rst       (rst),
   .icodeReq  (icodeReq),
   .dcodeReq  (dcodeReq),
   .codeReq   (codeReq),
   .codeResp  (codeResp),
   .icodeResp (icodeResp),
   .dcodeResp (dcodeResp),
   .iPending  (iPending),
   .dPending  (dPending),
   .iIssued   (iIssued),
   .dIssued   (dIssued),
   .ownValidQ (ownValidQ)
);

`default_nettype wire

/* rtl/cm3_bus_wrap.sv */
//==========================================================================
// Cortex-M3 bus logic top level
// Code bus mux for icode/dcode and exclusive monitor on the system bus
//==========================================================================
`timescale 1ns/1ps
`default_nettype none
`include "cm3_defines.svh"

module cm3_bus_wrap (
   input  logic                   HCLK,
   input  logic                   rst,

   // Icode master
   input  cm3_pkg::tIcodeReq      icodeReq,
   output cm3_pkg::tCodeResp      icodeResp,

   // Dcode master
   input  cm3_pkg::tDcodeReq      dcodeReq,
   input  logic [`CM3_DATA_W-1:0] dcodeWdata,
   output cm3_pkg::tCodeResp      dcodeResp,

   // Shared code bus
   output cm3_pkg::tCodeReq       codeReq,
   output logic [`CM3_DATA_W-1:0] codeWdata,
   input  cm3_pkg::tCodeResp      codeResp,

   // System bus, exclusive access only
   input  logic                   sysWriteIn,
   input  logic [`CM3_ADDR_W-1:0] sysAddr,
   input  logic                   sysExReq,
   input  logic                   sysReady,
   input  logic                   halted,
   output logic                   sysWrite,
   output logic                   sysExResp
);

   cm3_code_mux u_codeMux (
      .HCLK       (HCLK),
      .rst        (rst),
      .icodeReq   (icodeReq),
      .dcodeReq   (dcodeReq),
      .dcodeWdata (dcodeWdata),
      .codeResp   (codeResp),
      .icodeResp  (icodeResp),
      .dcodeResp  (dcodeResp),
      .codeReq    (codeReq),
      .codeWdata  (codeWdata)
   );

   // Exclusives stay disabled on the code bus, only the system bus is watched
   cm3_excl_mon u_sysMon (
      .HCLK     (HCLK),
      .rst      (rst),
      .halted   (halted),
      .addr     (sysAddr),
      .writeIn  (sysWriteIn),
      .exReq    (sysExReq),
      .ready    (sysReady),
      .writeOut (sysWrite),
      .exResp   (sysExResp)
   );

endmodule

`default_nettype wire

/* rtl/cm3_excl_mon.sv */
//==========================================================================
// Exclusive access monitor
// Tracks one word tag set by an exclusive load and turns a failing
// exclusive store into a read with a failure response
//==========================================================================
`timescale 1ns/1ps
`default_nettype none
`include "cm3_defines.svh"

module cm3_excl_mon (
   input  logic                   HCLK,
   input  logic                   rst,
   input  logic                   halted,   // Debug halt drops the reservation
   input  logic [`CM3_ADDR_W-1:0] addr,
   input  logic                   writeIn,  // HWRITE from the core
   input  logic                   exReq,
   input  logic                   ready,    // System bus HREADY
   output logic                   writeOut, // HWRITE to the bus
   output logic                   exResp
);

   logic [`CM3_ADDR_W-1:`CM3_EXCL_LSB] tagQ;
   logic                               tagValidQ;
   logic                               tagHit;
   logic                               exFail;

   assign tagHit = tagValidQ & (addr[`CM3_ADDR_W-1:`CM3_EXCL_LSB] == tagQ);

   // Exclusive store without a matching reservation
   assign exFail = exReq & writeIn & ~tagHit;

   assign writeOut = writeIn & ~exFail; // Failed store becomes a read

   always_ff @(posedge HCLK) begin
      if (rst) begin
         tagValidQ <= 1'b0;
      end else if (halted) begin
         tagValidQ <= 1'b0;
      end else if (ready && exReq) begin
         tagValidQ <= ~writeIn;   // Load sets, any exclusive store clears
      end
   end

   // Tag address only matters while valid
   always_ff @(posedge HCLK) begin
      if (ready && exReq && !writeIn) begin
         tagQ <= addr[`CM3_ADDR_W-1:`CM3_EXCL_LSB];
      end
   end

   // Response lives in the data phase, held through wait states
   always_ff @(posedge HCLK) begin
      if (rst) begin
         exResp <= 1'b0;
      end else if (ready) begin
         exResp <= exFail;
      end
   end

endmodule

`default_nettype wire

/* rtl/cm3_code_mux.sv */
//==========================================================================
// Icode/dcode code bus mux
// Fixed priority arbiter merging two AHB-lite masters onto one code bus,
// with data phase steering of read data, response and write data
//==========================================================================
`timescale 1ns/1ps
`default_nettype none
`include "cm3_defines.svh"

module cm3_code_mux (
   input  logic                   HCLK,
   input  logic                   rst,
   input  cm3_pkg::tIcodeReq      icodeReq,
   input  cm3_pkg::tDcodeReq      dcodeReq,
   input  logic [`CM3_DATA_W-1:0] dcodeWdata,
   input  cm3_pkg::tCodeResp      codeResp,
   output cm3_pkg::tCodeResp      icodeResp,
   output cm3_pkg::tCodeResp      dcodeResp,
   output cm3_pkg::tCodeReq       codeReq,
   output logic [`CM3_DATA_W-1:0] codeWdata
);
   import cm3_pkg::*;

   tIcodeReq iHeld;
   tDcodeReq dHeld;
   tIcodeReq iEff;
   tDcodeReq dEff;
   logic     iPending;
   logic     dPending;
   logic     iReady;
   logic     dReady;
   logic     iSel;
   logic     dSel;
   logic     iIssued;
   logic     dIssued;
   logic     lockQ;       // Address phase on the bus was stalled
   logic     lockDcodeQ;
   logic     ownValidQ;   // A data phase is in flight
   logic     ownDcodeQ;   // It belongs to dcode
   logic     iOwn;
   logic     dOwn;

   // A waiting master is stalled in its data phase
   assign iReady = ~iPending & codeResp.ready;
   assign dReady = ~dPending & codeResp.ready;

   assign iIssued = iSel & codeResp.ready;
   assign dIssued = dSel & codeResp.ready;

   cm3_addr_hold #(.tPayload(tIcodeReq)) u_iHold (
      .HCLK    (HCLK),
      .rst     (rst),
      .req     (icodeReq),
      .accept  (iReady),
      .issued  (iIssued),
      .pending (iPending),
      .held    (iHeld)
   );

   cm3_addr_hold #(.tPayload(tDcodeReq)) u_dHold (
      .HCLK    (HCLK),
      .rst     (rst),
      .req     (dcodeReq),
      .accept  (dReady),
      .issued  (dIssued),
      .pending (dPending),
      .held    (dHeld)
   );

   assign iEff = iPending ? iHeld : icodeReq;
   assign dEff = dPending ? dHeld : dcodeReq;

   // Held requests go first so a loser waits for one transfer only
   always_comb begin
      if (lockQ) begin
         dSel = lockDcodeQ;
      end else begin
         dSel = dPending | (~iPending & dcodeReq.trans[1]);
      end
      iSel = ~dSel & (iPending | icodeReq.trans[1]);
   end

   always_comb begin
      codeReq       = '0;
      codeReq.trans = `CM3_HTRANS_IDLE;
      if (dSel) begin
         codeReq = dEff;
      end else if (iSel) begin
         codeReq.trans = iEff.trans;   // Fetches are reads, write stays low
         codeReq.addr  = iEff.addr;
         codeReq.size  = iEff.size;
         codeReq.burst = iEff.burst;
         codeReq.prot  = iEff.prot;
      end
   end

   always_ff @(posedge HCLK) begin
      if (rst) begin
         lockQ      <= 1'b0;
         lockDcodeQ <= 1'b0;
         ownValidQ  <= 1'b0;
         ownDcodeQ  <= 1'b0;
      end else begin
         lockQ      <= (iSel | dSel) & ~codeResp.ready;
         lockDcodeQ <= dSel;
         if (codeResp.ready) begin
            ownValidQ <= iSel | dSel;
            ownDcodeQ <= dSel;
         end
      end
   end

   assign iOwn = ownValidQ & ~ownDcodeQ;
   assign dOwn = ownValidQ & ownDcodeQ;

   always_comb begin
      icodeResp.rdata = iOwn ? codeResp.rdata : '0;
      icodeResp.resp  = iOwn & codeResp.resp;
      icodeResp.ready = iReady;
      dcodeResp.rdata = dOwn ? codeResp.rdata : '0;
      dcodeResp.resp  = dOwn & codeResp.resp;
      dcodeResp.ready = dReady;
   end

   assign codeWdata = dOwn ? dcodeWdata : '0; // Only dcode writes

endmodule

`default_nettype wire

/* rtl/cm3_addr_hold.sv */
//==========================================================================
// Address phase holding register
// Keeps one master's accepted address phase until the code bus takes it
//==========================================================================
`timescale 1ns/1ps
`default_nettype none

module cm3_addr_hold #(
   parameter type tPayload = cm3_pkg::tIcodeReq
) (
   input  logic    HCLK,
   input  logic    rst,
   input  tPayload req,      // Live address phase from the master
   input  logic    accept,   // Master's HREADY
   input  logic    issued,   // Master owns the code bus address phase
   output logic    pending,
   output tPayload held
);

   logic reqActive;
   logic capture;

   // NONSEQ and SEQ both have bit 1 set
   assign reqActive = req.trans[1];

   // Accepted from the master but lost the bus this cycle
   assign capture = accept & reqActive & ~issued;

   always_ff @(posedge HCLK) begin
      if (rst) begin
         pending <= 1'b0;
      end else if (capture) begin
         pending <= 1'b1;
      end else if (issued) begin
         pending <= 1'b0;    // Held copy went out
      end
   end

   // Payload only, qualified by pending
   always_ff @(posedge HCLK) begin
      if (capture) begin
         held <= req;
      end
   end

endmodule

`default_nettype wire

/* rtl/cm3_pkg.sv */
//==========================================================================
// Cortex-M3 bus types
// Address phase and response structs for the icode, dcode and code buses
//==========================================================================
`default_nettype none
`include "cm3_defines.svh"

package cm3_pkg;

   // Instruction fetch address phase, always a read
   typedef struct packed {
      logic [1:0]             trans;
      logic [`CM3_ADDR_W-1:0] addr;
      logic [2:0]             size;
      logic [2:0]             burst;
      logic [3:0]             prot;
   } tIcodeReq;

   // Data side address phase
   typedef struct packed {
      logic [1:0]             trans;
      logic [`CM3_ADDR_W-1:0] addr;
      logic                   write;
      logic [2:0]             size;
      logic [2:0]             burst;
      logic [3:0]             prot;
   } tDcodeReq;

   // Shared code bus carries the full data side address phase
   typedef tDcodeReq tCodeReq;

   // Slave response, one layout for every code bus port
   typedef struct packed {
      logic [`CM3_DATA_W-1:0] rdata;
      logic                   ready; // HREADY
      logic                   resp;  // HRESP, error only
   } tCodeResp;

endpackage

`default_nettype wire

/* rtl/cm3_defines.svh */
//==========================================================================
// Cortex-M3 bus logic definitions
// Bus widths, AHB-lite transfer codes and the exclusive tag granule
//==========================================================================
`ifndef CM3_DEFINES_SVH
`define CM3_DEFINES_SVH

// AHB-lite bus widths
`define CM3_ADDR_W 32
`define CM3_DATA_W 32

// HTRANS encodings
`define CM3_HTRANS_IDLE   2'b00
`define CM3_HTRANS_NONSEQ 2'b10

// Lowest address bit compared by the exclusive monitor, word granule
`define CM3_EXCL_LSB 2

`endif
